// ==== rtl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    localparam int data_width = 32;

    // one address word, decoded by the bus fabric and by the SRAM controller
    typedef union packed {
        struct packed {
            logic [3:0]  region;    // top nibble picks the slave
            logic [27:0] offset;
        } bus;
        struct packed {
            logic [8:0]  pad;
            logic [20:0] word;      // 32-bit word index into SRAM
            logic [1:0]  byte_sel;
        } sram;
    } bus_addr_t;

    localparam logic [3:0] region_bootrom = 4'h1;  // instruction bus only
    localparam logic [3:0] region_sram    = 4'h8;  // both buses
    localparam logic [3:0] region_timer   = 4'hb;  // data bus only
    localparam logic [3:0] region_led     = 4'hc;  // data bus only

endpackage

`default_nettype wire

// ==== rtl/bootrom.sv ====
`timescale 1ns/1ns
`default_nettype none

module bootrom (
    input  logic [3:0]                      rom_index,
    output logic [soc_pkg::data_width-1:0]  rom_data
);

    // lui pattern with the word number in the immediate
    always_comb begin
        case (rom_index)
            4'd0:  rom_data = 32'h3c00_0000;
            4'd1:  rom_data = 32'h3c00_0001;
            4'd2:  rom_data = 32'h3c00_0002;
            4'd3:  rom_data = 32'h3c00_0003;
            4'd4:  rom_data = 32'h3c00_0004;
            4'd5:  rom_data = 32'h3c00_0005;
            4'd6:  rom_data = 32'h3c00_0006;
            4'd7:  rom_data = 32'h3c00_0007;
            4'd8:  rom_data = 32'h3c00_0008;
            4'd9:  rom_data = 32'h3c00_0009;
            4'd10: rom_data = 32'h3c00_000a;
            4'd11: rom_data = 32'h3c00_000b;
            4'd12: rom_data = 32'h3c00_000c;
            4'd13: rom_data = 32'h3c00_000d;
            4'd14: rom_data = 32'h3c00_000e;
            4'd15: rom_data = 32'h3c00_000f;
            default: rom_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module timer #(
    parameter int timer_width = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            sel,
    input  logic                            write,
    input  logic                            word,   // 0 count, 1 compare
    input  logic [soc_pkg::data_width-1:0]  wdata,
    output logic [soc_pkg::data_width-1:0]  rdata,
    output logic                            irq
);

    logic [timer_width-1:0] count;
    logic [timer_width-1:0] compare;

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            compare <= '1;                      // keeps irq quiet after reset
        end else begin
            count <= count + 1'b1;              // free running
            if (sel && write && word)
                compare <= wdata[timer_width-1:0];
        end
    end

    always_comb begin
        rdata = '0;                             // zero-extend narrow timers
        rdata[timer_width-1:0] = word ? compare : count;
    end

    assign irq = (count >= compare);            // level, not a pulse

    // only a wrap to zero may bring the count back down
    assert property (@(posedge clk) disable iff (reset)
        (count != '0) |-> (count > $past(count)))
        else $error("timer: count went backwards");

endmodule

`default_nettype wire

// ==== rtl/instruction_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruction_bus (
    input  logic                            clk,
    input  logic                            inst_read,
    input  soc_pkg::bus_addr_t              inst_addr,
    output logic [soc_pkg::data_width-1:0]  inst_rdata,
    output logic                            inst_stall,
    output logic [3:0]                      rom_index,
    input  logic [soc_pkg::data_width-1:0]  rom_data,
    output logic                            sram_read,
    output soc_pkg::bus_addr_t              sram_addr,
    input  logic [soc_pkg::data_width-1:0]  sram_rdata,
    input  logic                            sram_stall
);

    logic hit_rom;
    logic hit_sram;

    assign hit_rom   = (inst_addr.bus.region == soc_pkg::region_bootrom);
    assign hit_sram  = (inst_addr.bus.region == soc_pkg::region_sram);
    assign rom_index = inst_addr.bus.offset[5:2];   // word index in the rom
    assign sram_read = inst_read && hit_sram;
    assign sram_addr = inst_addr;

    assign inst_rdata = hit_rom ? rom_data : (hit_sram ? sram_rdata : '0);
    assign inst_stall = hit_sram && sram_stall;

    // the fetching master must hold its request across a stall
    assert property (@(posedge clk) inst_read && inst_stall |=> inst_read && $stable(inst_addr))
        else $error("instruction_bus: fetch changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/data_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_bus (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            data_read,
    input  logic                            data_write,
    input  soc_pkg::bus_addr_t              data_addr,
    input  logic [soc_pkg::data_width-1:0]  data_wdata,
    output logic [soc_pkg::data_width-1:0]  data_rdata,
    output logic                            data_stall,

    output logic                            sram_read,
    output logic                            sram_write,
    output soc_pkg::bus_addr_t              sram_addr,
    output logic [soc_pkg::data_width-1:0]  sram_wdata,
    input  logic [soc_pkg::data_width-1:0]  sram_rdata,
    input  logic                            sram_stall,

    output logic                            timer_sel,
    output logic                            timer_write,
    output logic                            timer_word,
    input  logic [soc_pkg::data_width-1:0]  timer_rdata,

    output logic [15:0]                     leds
);

    logic [3:0] region;
    logic       hit_sram;
    logic       hit_timer;
    logic       hit_led;

    assign region    = data_addr.bus.region;
    assign hit_sram  = (region == soc_pkg::region_sram);
    assign hit_timer = (region == soc_pkg::region_timer);
    assign hit_led   = (region == soc_pkg::region_led);

    assign sram_read   = data_read && hit_sram;
    assign sram_write  = data_write && hit_sram;
    assign sram_addr   = data_addr;
    assign sram_wdata  = data_wdata;

    assign timer_sel   = (data_read || data_write) && hit_timer;
    assign timer_write = data_write && hit_timer;
    assign timer_word  = data_addr.bus.offset[2];   // +4 selects compare

    always_ff @(posedge clk) begin
        if (reset)
            leds <= '0;
        else if (data_write && hit_led)
            leds <= data_wdata[15:0];
    end

    // only SRAM can hold the bus, everything else answers at once
    always_comb begin
        data_rdata = '0;
        data_stall = 1'b0;
        if (hit_sram) begin
            data_rdata = sram_rdata;
            data_stall = sram_stall;
        end else if (hit_timer) begin
            data_rdata = timer_rdata;
        end else if (hit_led) begin
            data_rdata = {{(soc_pkg::data_width-16){1'b0}}, leds};
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(data_read && data_write))
        else $error("data_bus: read and write strobes high together");

endmodule

`default_nettype wire

// ==== rtl/sram_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_controller #(
    parameter int sram_addr_width = 20
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                inst_read,
    input  soc_pkg::bus_addr_t                  inst_addr,
    output logic [soc_pkg::data_width-1:0]      inst_rdata,
    output logic                                inst_stall,

    input  logic                                data_read,
    input  logic                                data_write,
    input  soc_pkg::bus_addr_t                  data_addr,
    input  logic [soc_pkg::data_width-1:0]      data_wdata,
    output logic [soc_pkg::data_width-1:0]      data_rdata,
    output logic                                data_stall,

    output logic [sram_addr_width-1:0]          sram_addr,
    output logic [soc_pkg::data_width-1:0]      sram_dout,
    input  logic [soc_pkg::data_width-1:0]      sram_din,
    output logic                                sram_ce_n,
    output logic                                sram_oe_n,
    output logic                                sram_we_n
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_access = 2'd1;
    localparam logic [1:0] st_done   = 2'd2;

    logic [1:0]                         state;
    logic                               grant_data;  // 1 = data bus owns the cycle
    logic                               is_write;
    logic                               data_req;
    logic [sram_addr_width-1:0]         addr_q;
    logic [soc_pkg::data_width-1:0]     wdata_q;
    logic [soc_pkg::data_width-1:0]     rdata_q;

    assign data_req = data_read | data_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            grant_data <= 1'b0;
            is_write   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (data_req) begin         // data side wins
                        state      <= st_access;
                        grant_data <= 1'b1;
                        is_write   <= data_write;
                    end else if (inst_read) begin
                        state      <= st_access;
                        grant_data <= 1'b0;
                        is_write   <= 1'b0;
                    end
                end
                st_access: state <= st_done;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            addr_q  <= data_req ? data_addr.sram.word[sram_addr_width-1:0]
                                : inst_addr.sram.word[sram_addr_width-1:0];
            wdata_q <= data_wdata;
        end
        if (state == st_access && !is_write)
            rdata_q <= sram_din;                // sample at end of the strobe
    end

    assign sram_addr  = addr_q;
    assign sram_dout  = wdata_q;
    assign sram_ce_n  = (state != st_access);
    assign sram_oe_n  = !(state == st_access && !is_write);
    assign sram_we_n  = !(state == st_access && is_write);

    assign inst_rdata = rdata_q;
    assign data_rdata = rdata_q;
    assign inst_stall = inst_read && !(state == st_done && !grant_data);
    assign data_stall = data_req && !(state == st_done && grant_data);

    assert property (@(posedge clk) disable iff (reset) !(!sram_we_n && !sram_oe_n))
        else $error("sram_controller: we_n and oe_n low together");

    // both masters pending, only the granted one may see stall drop
    assert property (@(posedge clk) disable iff (reset)
        !(inst_read && !inst_stall && data_req && !data_stall))
        else $error("sram_controller: both stalls released in one cycle");

    // granted master must still hold its request when done arrives
    assert property (@(posedge clk) disable iff (reset)
        (state == st_done) |-> (grant_data ? data_req : inst_read))
        else $error("sram_controller: request dropped before completion");

endmodule

`default_nettype wire

// ==== rtl/thinpad_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module thinpad_soc #(
    parameter int sram_addr_width = 20,
    parameter int timer_width     = 32
) (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            inst_read,
    input  soc_pkg::bus_addr_t              inst_addr,
    output logic [soc_pkg::data_width-1:0]  inst_rdata,
    output logic                            inst_stall,

    input  logic                            data_read,
    input  logic                            data_write,
    input  soc_pkg::bus_addr_t              data_addr,
    input  logic [soc_pkg::data_width-1:0]  data_wdata,
    output logic [soc_pkg::data_width-1:0]  data_rdata,
    output logic                            data_stall,

    output logic [sram_addr_width-1:0]      sram_addr,     // base_ram word address
    output logic [soc_pkg::data_width-1:0]  sram_dout,
    input  logic [soc_pkg::data_width-1:0]  sram_din,
    output logic                            sram_ce_n,
    output logic                            sram_oe_n,
    output logic                            sram_we_n,

    output logic [15:0]                     leds,
    output logic                            irq
);

    logic [3:0]                     rom_index;
    logic [soc_pkg::data_width-1:0] rom_data;

    logic                           inst_ram_read;
    soc_pkg::bus_addr_t             inst_ram_addr;
    logic [soc_pkg::data_width-1:0] inst_ram_rdata;
    logic                           inst_ram_stall;

    logic                           data_ram_read;
    logic                           data_ram_write;
    soc_pkg::bus_addr_t             data_ram_addr;
    logic [soc_pkg::data_width-1:0] data_ram_wdata;
    logic [soc_pkg::data_width-1:0] data_ram_rdata;
    logic                           data_ram_stall;

    logic                           timer_sel;
    logic                           timer_write;
    logic                           timer_word;
    logic [soc_pkg::data_width-1:0] timer_rdata;

    instruction_bus instruction_bus_instance (
        .clk        (clk),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_stall (inst_stall),
        .rom_index  (rom_index),
        .rom_data   (rom_data),
        .sram_read  (inst_ram_read),
        .sram_addr  (inst_ram_addr),
        .sram_rdata (inst_ram_rdata),
        .sram_stall (inst_ram_stall)
    );

    data_bus data_bus_instance (
        .clk         (clk),
        .reset       (reset),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .data_stall  (data_stall),
        .sram_read   (data_ram_read),
        .sram_write  (data_ram_write),
        .sram_addr   (data_ram_addr),
        .sram_wdata  (data_ram_wdata),
        .sram_rdata  (data_ram_rdata),
        .sram_stall  (data_ram_stall),
        .timer_sel   (timer_sel),
        .timer_write (timer_write),
        .timer_word  (timer_word),
        .timer_rdata (timer_rdata),
        .leds        (leds)
    );

    bootrom bootrom_instance (
        .rom_index (rom_index),
        .rom_data  (rom_data)
    );

    sram_controller #(
        .sram_addr_width (sram_addr_width)
    ) sram_controller_instance (
        .clk        (clk),
        .reset      (reset),
        .inst_read  (inst_ram_read),
        .inst_addr  (inst_ram_addr),
        .inst_rdata (inst_ram_rdata),
        .inst_stall (inst_ram_stall),
        .data_read  (data_ram_read),
        .data_write (data_ram_write),
        .data_addr  (data_ram_addr),
        .data_wdata (data_ram_wdata),
        .data_rdata (data_ram_rdata),
        .data_stall (data_ram_stall),
        .sram_addr  (sram_addr),
        .sram_dout  (sram_dout),
        .sram_din   (sram_din),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n)
    );

    timer #(
        .timer_width (timer_width)
    ) timer_instance (
        .clk   (clk),
        .reset (reset),
        .sel   (timer_sel),
        .write (timer_write),
        .word  (timer_word),
        .wdata (data_wdata),
        .rdata (timer_rdata),
        .irq   (irq)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;   // 50 % duty
    end

endmodule

`default_nettype wire

// ==== tb/sram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_model #(
    parameter int addr_width = 20
) (
    input  logic [addr_width-1:0] addr,
    input  logic [31:0]           wdata,
    output logic [31:0]           rdata,
    input  logic                  ce_n,
    input  logic                  oe_n,
    input  logic                  we_n
);

    logic [31:0] mem [0:(1 << addr_width)-1];

    function automatic logic [31:0] fill_word(input logic [31:0] address);
        return 32'h5a5a_0000 ^ (address * 32'h9e37_79b1);  // odd multiplier, all bits count
    endfunction

    initial begin
        for (int i = 0; i < (1 << addr_width); i++)
            mem[i[addr_width-1:0]] = fill_word(i);
    end

    // word is taken as write enable rises, address and data still held
    always @(posedge we_n) begin
        if (!$isunknown(addr))
            mem[addr] = wdata;
    end

    assign rdata = (!ce_n && !oe_n) ? mem[addr] : '0;  // async read path

endmodule

`default_nettype wire

// ==== tb/thinpad_soc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module thinpad_soc_tb;

    localparam int bus_timeout = 16;
    localparam int irq_timeout = 60;
    localparam int sram_writes = 12;

    logic        clk;
    logic        reset;
    logic        inst_read;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_stall;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic        data_stall;
    logic [19:0] sram_addr;
    logic [31:0] sram_dout;
    logic [31:0] sram_din;
    logic        sram_ce_n;
    logic        sram_oe_n;
    logic        sram_we_n;
    logic [15:0] leds;
    logic        irq;

    logic [31:0] inst_expected;     // set by the stimulus
    logic [31:0] data_expected;
    logic        data_check;
    logic        race_on;
    logic        irq_quiet;

    logic        data_done_q;       // monitor state, updated at rising edges
    logic        inst_done_q;
    logic [31:0] data_rdata_q;
    logic        data_first;
    logic [31:0] last_count;
    logic        have_last;
    logic [15:0] led_expected;
    logic        led_check;
    logic        count_read;

    int          check_errors;
    int          timeout_errors;
    logic [31:0] lfsr_state;
    logic [31:0] scoreboard [logic [19:0]];
    logic [19:0] written [$];

    tb_clock #(.period(20)) clock_gen (.clk(clk));

    sram_model #(.addr_width(20)) sram (
        .addr  (sram_addr),
        .wdata (sram_dout),
        .rdata (sram_din),
        .ce_n  (sram_ce_n),
        .oe_n  (sram_oe_n),
        .we_n  (sram_we_n)
    );

    thinpad_soc #(
        .sram_addr_width (20),
        .timer_width     (32)
    ) thinpad_soc_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_stall (inst_stall),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_stall (data_stall),
        .sram_addr  (sram_addr),
        .sram_dout  (sram_dout),
        .sram_din   (sram_din),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n),
        .leds       (leds),
        .irq        (irq)
    );

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return value;
    endfunction

    function automatic logic [31:0] boot_word(input logic [3:0] index);
        return 32'h3c00_0000 + {28'h0, index};      // lui with the word number
    endfunction

    function automatic logic [31:0] sram_address(input logic [19:0] index);
        return {4'h8, 6'h0, index, 2'b00};
    endfunction

    function automatic logic data_mapped(input logic [3:0] region);
        return region == 4'h8 || region == 4'hb || region == 4'hc;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        check_errors++;
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic data_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                               input logic check, input logic [31:0] expected);
        int cycles;
        @(negedge clk);
        data_read     = !wr;
        data_write    = wr;
        data_addr     = addr;
        data_wdata    = wdata;
        data_check    = check;
        data_expected = expected;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!data_done_q && cycles < bus_timeout);
        if (!data_done_q) begin
            timeout_errors++;
            $display("timeout: data access to %h did not complete", addr);
        end
        data_read  = 1'b0;
        data_write = 1'b0;
        data_check = 1'b0;
    endtask

    task automatic inst_fetch(input logic [31:0] addr, input logic [31:0] expected);
        int cycles;
        @(negedge clk);
        inst_read     = 1'b1;
        inst_addr     = addr;
        inst_expected = expected;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!inst_done_q && cycles < bus_timeout);
        if (!inst_done_q) begin
            timeout_errors++;
            $display("timeout: instruction fetch from %h did not complete", addr);
        end
        inst_read = 1'b0;
    endtask

    task automatic wait_for_irq();
        int cycles;
        cycles = 0;
        while (!irq && cycles < irq_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq) begin
            timeout_errors++;
            $display("timeout: timer interrupt did not rise within %0d cycles", irq_timeout);
        end
    endtask

    assign count_read = data_read && data_addr[31:28] == 4'hb && !data_addr[2];

    always @(posedge clk) begin
        data_done_q  <= (data_read || data_write) && !data_stall;
        inst_done_q  <= inst_read && !inst_stall;
        data_rdata_q <= data_rdata;
        led_check    <= data_write && !data_stall && data_addr[31:28] == 4'hc;
        if (data_write && !data_stall && data_addr[31:28] == 4'hc)
            led_expected <= data_wdata[15:0];
        if (!race_on)
            data_first <= 1'b0;
        else if ((data_read || data_write) && !data_stall)
            data_first <= 1'b1;                 // data side finished first
        if (reset) begin
            have_last <= 1'b0;
        end else if (count_read && !data_stall) begin
            have_last  <= 1'b1;
            last_count <= data_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        inst_read && inst_addr[31:28] == 4'h1 |-> !inst_stall)
        else report_mismatch("boot_stall", 32'h0, {31'h0, $sampled(inst_stall)});

    assert property (@(posedge clk) disable iff (reset)
        inst_read && inst_addr[31:28] == 4'h1 |-> inst_rdata == boot_word(inst_addr[5:2]))
        else report_mismatch("boot_fetch", boot_word($sampled(inst_addr[5:2])),
                             $sampled(inst_rdata));

    assert property (@(posedge clk) disable iff (reset)
        inst_read && !inst_stall && inst_addr[31:28] == 4'h8 |-> inst_rdata == inst_expected)
        else report_mismatch("inst_sram", $sampled(inst_expected), $sampled(inst_rdata));

    assert property (@(posedge clk) disable iff (reset)
        data_read && !data_stall && data_check |-> data_rdata == data_expected)
        else report_mismatch("data_read", $sampled(data_expected), $sampled(data_rdata));

    assert property (@(posedge clk) disable iff (reset)
        (data_read || data_write) && !data_mapped(data_addr[31:28]) |-> !data_stall)
        else report_mismatch("unmapped_stall", 32'h0, {31'h0, $sampled(data_stall)});

    assert property (@(posedge clk) disable iff (reset)
        race_on && inst_read && !inst_stall |-> data_first)
        else report_mismatch("contention_order", 32'h1, {31'h0, $sampled(data_first)});

    assert property (@(posedge clk) disable iff (reset) irq_quiet |-> !irq)
        else report_mismatch("irq_after_write", 32'h0, {31'h0, $sampled(irq)});

    assert property (@(posedge clk) disable iff (reset)
        count_read && !data_stall && have_last |-> data_rdata >= last_count)
        else report_mismatch("count_order", $sampled(last_count), $sampled(data_rdata));

    assert property (@(posedge clk) disable iff (reset) led_check |-> leds == led_expected)
        else report_mismatch("leds", {16'h0, $sampled(led_expected)}, {16'h0, $sampled(leds)});

    initial begin
        logic [19:0] index;
        logic [31:0] word;
        logic [31:0] count;
        reset          = 1'b1;
        inst_read      = 1'b0;
        inst_addr      = '0;
        data_read      = 1'b0;
        data_write     = 1'b0;
        data_addr      = '0;
        data_wdata     = '0;
        inst_expected  = '0;
        data_expected  = '0;
        data_check     = 1'b0;
        race_on        = 1'b0;
        irq_quiet      = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        lfsr_state     = 32'hc805_2777;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 16; i++)
            inst_fetch({4'h1, 22'h0, i[3:0], 2'b00}, 32'h0);

        for (int i = 0; i < sram_writes; i++) begin
            word  = take_bits(20);
            index = word[19:0];
            word  = take_bits(32);
            scoreboard[index] = word;
            written.push_back(index);
            data_access(1'b1, sram_address(index), word, 1'b0, 32'h0);
        end
        foreach (written[i])
            data_access(1'b0, sram_address(written[i]), 32'h0, 1'b1, scoreboard[written[i]]);

        inst_fetch(sram_address(written[0]), scoreboard[written[0]]);

        // fetch must see the word the data side writes first
        index = written[1];
        word  = take_bits(32);
        scoreboard[index] = word;
        race_on = 1'b1;
        fork
            data_access(1'b1, sram_address(index), word, 1'b0, 32'h0);
            inst_fetch(sram_address(index), word);
        join
        race_on = 1'b0;

        data_access(1'b0, 32'hb000_0000, 32'h0, 1'b0, 32'h0);
        count = data_rdata_q;
        data_access(1'b1, 32'hb000_0004, count + 32'd50, 1'b0, 32'h0);
        irq_quiet = 1'b1;
        @(negedge clk);
        irq_quiet = 1'b0;
        wait_for_irq();
        data_access(1'b0, 32'hb000_0000, 32'h0, 1'b0, 32'h0);

        word = take_bits(32);
        data_access(1'b1, 32'hc000_0000, word, 1'b0, 32'h0);
        data_access(1'b0, 32'h3000_0010, 32'h0, 1'b1, 32'h0);
        word = take_bits(32);
        data_access(1'b1, 32'h5000_0020, word, 1'b0, 32'h0);
        @(negedge clk);

        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== thinpad_bus.f ====
rtl/soc_pkg.sv
rtl/bootrom.sv
rtl/timer.sv
rtl/instruction_bus.sv
rtl/data_bus.sv
rtl/sram_controller.sv
rtl/thinpad_soc.sv
tb/tb_clock.sv
tb/sram_model.sv
tb/thinpad_soc_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := thinpad_soc_tb
FILELIST := thinpad_bus.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Regression passed'

clean:
	rm -rf $(BUILD_DIR)
